// File: hdl/riscv_csr_consts.svh
`ifndef RISCV_CSR_CONSTS_SVH
`define RISCV_CSR_CONSTS_SVH

`define CSR_XLEN   64  // mxlen fixed, rv64 only
`define CSR_ADDR_W 12

// machine info, all read only (bits 11:10 = 3)
`define CSR_MVENDORID  12'hF11
`define CSR_MARCHID    12'hF12
`define CSR_MIMPID     12'hF13
`define CSR_MHARTID    12'hF14
`define CSR_MCONFIGPTR 12'hF15

// trap setup
`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MCOUNTINHIBIT 12'h320

// trap handling
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MIP      12'h344

// counters
`define CSR_MCYCLE   12'hB00
`define CSR_MINSTRET 12'hB02

`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LO   11  // mpp is 12:11
`define MSTATUS_UXL_LO   32  // uxl is 33:32

`define IRQ_MTI_BIT 7   // same position in mie and mip
`define IRQ_MEI_BIT 11

// mxl=2 (64 bit), extensions u m i c a
`define MISA_CODE   64'h8000_0000_0010_1105
`define MTVEC_RESET 64'h0000_0000_003F_FFFC  // direct mode
`define MCAUSE_CODE_W 4

`endif

// File: hdl/riscv_csr_counters.sv
`include "riscv_csr_consts.svh"

module riscv_csr_counters (
  input  logic                   i_riscv_csr_clk,
  input  logic                   i_riscv_csr_rst,
  input  riscv_csr_pkg::csr_wr_t i_wr,
  input  logic                   i_instret,
  output logic [`CSR_XLEN-1:0]   o_mcycle,
  output logic [`CSR_XLEN-1:0]   o_minstret,
  output logic [2:0]             o_mcountinhibit
);

  logic cyc_we;
  logic ret_we;
  logic inh_we;
  logic cyc_inc;
  logic ret_inc;

  assign cyc_we = i_wr.we && (i_wr.addr == `CSR_MCYCLE);
  assign ret_we = i_wr.we && (i_wr.addr == `CSR_MINSTRET);
  assign inh_we = i_wr.we && (i_wr.addr == `CSR_MCOUNTINHIBIT);

  assign cyc_inc = ~o_mcountinhibit[0];              // cy
  assign ret_inc = i_instret & ~o_mcountinhibit[2];  // ir

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mcycle        <= '0;
      o_minstret      <= '0;
      o_mcountinhibit <= '0;
    end
    else
    begin
      if (inh_we)
        o_mcountinhibit <= {i_wr.data[2], 1'b0, i_wr.data[0]};  // no time counter, bit 1 stays 0
      // csr write takes priority over the count
      if (cyc_we)
        o_mcycle <= i_wr.data;
      else if (cyc_inc)
        o_mcycle <= o_mcycle + 64'd1;
      if (ret_we)
        o_minstret <= i_wr.data;
      else if (ret_inc)
        o_minstret <= o_minstret + 64'd1;
    end
  end

endmodule

// File: hdl/riscv_csr_machine_regs.sv
`include "riscv_csr_consts.svh"

module riscv_csr_machine_regs (
  input  logic                    i_riscv_csr_clk,
  input  logic                    i_riscv_csr_rst,
  input  riscv_csr_pkg::csr_wr_t  i_wr,
  input  riscv_csr_pkg::irq_vec_t i_irq,
  output riscv_csr_pkg::irq_vec_t o_mie,
  output riscv_csr_pkg::irq_vec_t o_mip,
  output logic [`CSR_XLEN-1:0]    o_mtvec,
  output logic [`CSR_XLEN-1:0]    o_mscratch
);

  logic       mie_we;
  logic       mtvec_we;
  logic       mscratch_we;
  logic [5:0] base_mid;   // mtvec bits 7:2

  assign mie_we      = i_wr.we && (i_wr.addr == `CSR_MIE);
  assign mtvec_we    = i_wr.we && (i_wr.addr == `CSR_MTVEC);
  assign mscratch_we = i_wr.we && (i_wr.addr == `CSR_MSCRATCH);

  // vectored mode needs a 256 byte aligned base
  assign base_mid = i_wr.data[0] ? 6'b0 : i_wr.data[7:2];

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mie      <= '0;
      o_mip      <= '0;
      o_mtvec    <= `MTVEC_RESET;
      o_mscratch <= '0;
    end
    else
    begin
      o_mip <= i_irq;  // pending bits track the pins, sw writes ignored
      if (mie_we)
      begin
        o_mie.ext   <= i_wr.data[`IRQ_MEI_BIT];
        o_mie.timer <= i_wr.data[`IRQ_MTI_BIT];
      end
      if (mtvec_we)
        o_mtvec <= {i_wr.data[`CSR_XLEN-1:8], base_mid, 1'b0, i_wr.data[0]};  // mode bit 1 reserved
      if (mscratch_we)
        o_mscratch <= i_wr.data;
    end
  end

endmodule

// File: hdl/riscv_csr_op_decode.sv
`include "riscv_csr_consts.svh"

module riscv_csr_op_decode (
  input  logic [`CSR_ADDR_W-1:0]   i_riscv_csr_address,
  input  riscv_csr_pkg::csr_op_e   i_riscv_csr_op,
  input  logic [`CSR_XLEN-1:0]     i_riscv_csr_wdata,
  input  logic                     i_riscv_csr_globstall,
  input  logic [`CSR_XLEN-1:0]     i_rdata,         // current value, for set/clear
  input  logic                     i_addr_missing,
  input  riscv_csr_pkg::priv_lvl_e i_priv,
  output riscv_csr_pkg::csr_wr_t   o_wr,
  output logic                     o_read_en,
  output logic                     o_mret,
  output logic                     o_csr_illegal
);
  import riscv_csr_pkg::*;

  logic                 wr_intent;  // op wants to modify the csr
  logic                 ill_priv;
  logic                 ill_ro;
  logic [`CSR_XLEN-1:0] merged;

  always_comb
  begin
    o_read_en = 1'b0;
    wr_intent = 1'b0;
    o_mret    = 1'b0;
    case (i_riscv_csr_op)
      CSR_WRITE, CSR_SET, CSR_CLEAR:
      begin
        o_read_en = 1'b1;
        wr_intent = 1'b1;
      end
      CSR_READ: o_read_en = 1'b1;
      CSR_MRET: o_mret = 1'b1;   // no csr access at all
      default:  wr_intent = 1'b0;  // nop codes
    endcase
  end

  // set/clear merge with the value read this cycle
  always_comb
  begin
    case (i_riscv_csr_op)
      CSR_SET:   merged = i_rdata | i_riscv_csr_wdata;
      CSR_CLEAR: merged = i_rdata & ~i_riscv_csr_wdata;
      default:   merged = i_riscv_csr_wdata;
    endcase
  end

  // bits 9:8 give the lowest priv allowed, 11:10 == 3 marks read only
  assign ill_priv = o_read_en && (i_riscv_csr_address[9:8] > i_priv);
  assign ill_ro   = wr_intent && (i_riscv_csr_address[11:10] == 2'b11);

  assign o_csr_illegal = ill_priv | ill_ro | (o_read_en & i_addr_missing);

  // stall only blocks the write, the illegal flag still goes out
  assign o_wr.we   = wr_intent & ~o_csr_illegal & ~i_riscv_csr_globstall;
  assign o_wr.addr = i_riscv_csr_address;
  assign o_wr.data = merged;

endmodule

// File: hdl/riscv_csr_pkg.sv
`include "riscv_csr_consts.svh"

package riscv_csr_pkg;

  // csr instruction class from the decoder, codes 0, 4 and 6 do nothing
  typedef enum logic [2:0] {
    CSR_NOP   = 3'd0,
    CSR_WRITE = 3'd1,
    CSR_SET   = 3'd2,
    CSR_CLEAR = 3'd3,
    CSR_READ  = 3'd5,
    CSR_MRET  = 3'd7
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_lvl_e;

  typedef enum logic [`MCAUSE_CODE_W-1:0] {
    MC_INST_MISALIGNED  = 4'd0,
    MC_ILLEGAL          = 4'd2,
    MC_LOAD_MISALIGNED  = 4'd4,
    MC_STORE_MISALIGNED = 4'd6,
    MC_M_TIMER          = 4'd7,   // interrupt
    MC_ECALL_U          = 4'd8,
    MC_ECALL_M          = 4'd11
  } mcause_code_e;

  // machine external irq shares code 11 with ecall from m
  localparam mcause_code_e MC_M_EXT = MC_ECALL_M;

  typedef struct packed {
    logic illegal_inst;     // from decoder
    logic ecall;            // cause code picked by current priv
    logic inst_misaligned;
    logic load_misaligned;
    logic store_misaligned;
  } exc_vec_t;

  typedef struct packed {
    logic ext;
    logic timer;
  } irq_vec_t;

  // write request after legality and stall gating
  typedef struct packed {
    logic                   we;
    logic [`CSR_ADDR_W-1:0] addr;
    logic [`CSR_XLEN-1:0]   data;  // already merged for set/clear
  } csr_wr_t;

  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } mstatus_t;

endpackage

// File: hdl/riscv_csr_read_mux.sv
`include "riscv_csr_consts.svh"

module riscv_csr_read_mux (
  input  logic [`CSR_ADDR_W-1:0]    i_address,
  input  logic                      i_read_en,
  input  riscv_csr_pkg::mstatus_t   i_mstatus,
  input  riscv_csr_pkg::irq_vec_t   i_mie,
  input  riscv_csr_pkg::irq_vec_t   i_mip,
  input  logic [`CSR_XLEN-1:0]      i_mtvec,
  input  logic [`CSR_XLEN-1:0]      i_mscratch,
  input  logic [`CSR_XLEN-1:0]      i_mepc,
  input  logic [`MCAUSE_CODE_W:0]   i_mcause,  // {interrupt, code}
  input  logic [`CSR_XLEN-1:0]      i_mtval,
  input  logic [`CSR_XLEN-1:0]      i_mcycle,
  input  logic [`CSR_XLEN-1:0]      i_minstret,
  input  logic [2:0]                i_mcountinhibit,
  output logic [`CSR_XLEN-1:0]      o_rdata,
  output logic                      o_addr_missing
);

  always_comb
  begin
    o_rdata        = '0;
    o_addr_missing = 1'b0;
    if (i_read_en)
    begin
      case (i_address)
        `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID,
        `CSR_MHARTID, `CSR_MCONFIGPTR: o_rdata = '0;  // not implemented, read zero
        `CSR_MISA: o_rdata = `MISA_CODE;
        `CSR_MSTATUS:
        begin
          o_rdata[`MSTATUS_UXL_LO+1:`MSTATUS_UXL_LO] = 2'b10;  // u mode is 64 bit
          o_rdata[`MSTATUS_MIE_BIT]                  = i_mstatus.mie;
          o_rdata[`MSTATUS_MPIE_BIT]                 = i_mstatus.mpie;
          o_rdata[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO] = i_mstatus.mpp;
        end
        `CSR_MIE:
        begin
          o_rdata[`IRQ_MEI_BIT] = i_mie.ext;
          o_rdata[`IRQ_MTI_BIT] = i_mie.timer;
        end
        `CSR_MIP:
        begin
          o_rdata[`IRQ_MEI_BIT] = i_mip.ext;
          o_rdata[`IRQ_MTI_BIT] = i_mip.timer;
        end
        `CSR_MTVEC:         o_rdata = i_mtvec;
        `CSR_MSCRATCH:      o_rdata = i_mscratch;
        `CSR_MEPC:          o_rdata = i_mepc;
        `CSR_MCAUSE:
        begin
          o_rdata[`CSR_XLEN-1]          = i_mcause[`MCAUSE_CODE_W];  // interrupt flag
          o_rdata[`MCAUSE_CODE_W-1:0]   = i_mcause[`MCAUSE_CODE_W-1:0];
        end
        `CSR_MTVAL:         o_rdata = i_mtval;
        `CSR_MCYCLE:        o_rdata = i_mcycle;
        `CSR_MINSTRET:      o_rdata = i_minstret;
        `CSR_MCOUNTINHIBIT: o_rdata[2:0] = i_mcountinhibit;
        default:            o_addr_missing = 1'b1;  // becomes illegal inst in decode
      endcase
    end
  end

endmodule

// File: hdl/riscv_csr_trap_unit.sv
`include "riscv_csr_consts.svh"

module riscv_csr_trap_unit (
  input  logic                     i_riscv_csr_clk,
  input  logic                     i_riscv_csr_rst,
  input  riscv_csr_pkg::irq_vec_t  i_irq,
  input  riscv_csr_pkg::exc_vec_t  i_exc,
  input  logic                     i_csr_illegal,  // bad csr access
  input  riscv_csr_pkg::irq_vec_t  i_mie,
  input  logic                     i_mret,
  input  riscv_csr_pkg::csr_wr_t   i_wr,
  input  logic [`CSR_XLEN-1:0]     i_pc,
  input  logic [`CSR_XLEN-1:0]     i_address_alu,
  output logic                     o_goto_trap,
  output logic                     o_return_from_trap,
  output riscv_csr_pkg::mstatus_t  o_mstatus,
  output riscv_csr_pkg::priv_lvl_e o_priv,
  output logic [`CSR_XLEN-1:0]     o_mepc,
  output logic [`MCAUSE_CODE_W:0]  o_mcause,   // {interrupt, code}
  output logic [`CSR_XLEN-1:0]     o_mtval
);
  import riscv_csr_pkg::*;

  logic         ext_pend;
  logic         tim_pend;
  logic         illegal;
  logic         is_exc;
  logic         cause_int;
  mcause_code_e cause_code;
  logic         tval_cap;   // trap cause carries a faulting address

  // global enable, per-source enable and the live input
  assign ext_pend = o_mstatus.mie & i_mie.ext & i_irq.ext;
  assign tim_pend = o_mstatus.mie & i_mie.timer & i_irq.timer;
  assign illegal  = i_exc.illegal_inst | i_csr_illegal;
  assign is_exc   = illegal | i_exc.ecall | i_exc.inst_misaligned |
                    i_exc.load_misaligned | i_exc.store_misaligned;

  assign o_goto_trap        = ext_pend | tim_pend | is_exc;
  assign o_return_from_trap = i_mret & ~o_goto_trap;  // trap beats mret

  // fixed priority, interrupts first
  always_comb
  begin
    cause_int  = 1'b0;
    cause_code = MC_INST_MISALIGNED;
    if (ext_pend)
    begin
      cause_int  = 1'b1;
      cause_code = MC_M_EXT;
    end
    else if (tim_pend)
    begin
      cause_int  = 1'b1;
      cause_code = MC_M_TIMER;
    end
    else if (illegal)
      cause_code = MC_ILLEGAL;
    else if (i_exc.inst_misaligned)
      cause_code = MC_INST_MISALIGNED;
    else if (i_exc.ecall)
      cause_code = (o_priv == PRIV_M) ? MC_ECALL_M : MC_ECALL_U;
    else if (i_exc.load_misaligned)
      cause_code = MC_LOAD_MISALIGNED;
    else if (i_exc.store_misaligned)
      cause_code = MC_STORE_MISALIGNED;
  end

  assign tval_cap = ~cause_int &&
                    (cause_code == MC_LOAD_MISALIGNED || cause_code == MC_STORE_MISALIGNED);

  always_ff @(posedge i_riscv_csr_clk or posedge i_riscv_csr_rst)
  begin
    if (i_riscv_csr_rst)
    begin
      o_mstatus <= '{mie: 1'b0, mpie: 1'b0, mpp: PRIV_U};
      o_priv    <= PRIV_M;   // boot in machine mode
      o_mepc    <= '0;
      o_mcause  <= '0;
      o_mtval   <= '0;
    end
    else
    begin
      if (o_goto_trap)
      begin
        o_mstatus.mpie <= o_mstatus.mie;
        o_mstatus.mie  <= 1'b0;
        o_mstatus.mpp  <= o_priv;
        o_priv         <= PRIV_M;
        o_mepc         <= i_pc - 64'd4;
        o_mcause       <= {cause_int, cause_code};
      end
      else if (o_return_from_trap)
      begin
        o_mstatus.mie  <= o_mstatus.mpie;
        o_mstatus.mpie <= 1'b1;
        o_mstatus.mpp  <= PRIV_U;
        o_priv         <= o_mstatus.mpp;
      end
      else if (i_wr.we)
      begin
        if (i_wr.addr == `CSR_MSTATUS)
        begin
          o_mstatus.mie  <= i_wr.data[`MSTATUS_MIE_BIT];
          o_mstatus.mpie <= i_wr.data[`MSTATUS_MPIE_BIT];
          // only u and m exist, any other mpp value maps to u
          o_mstatus.mpp  <= (i_wr.data[`MSTATUS_MPP_LO+1:`MSTATUS_MPP_LO] == 2'b11) ?
                            PRIV_M : PRIV_U;
        end
        if (i_wr.addr == `CSR_MEPC)
          o_mepc <= {i_wr.data[`CSR_XLEN-1:1], 1'b0};
        if (i_wr.addr == `CSR_MCAUSE)
          o_mcause <= {i_wr.data[`CSR_XLEN-1], i_wr.data[`MCAUSE_CODE_W-1:0]};
      end

      // mtval only taken over by misaligned load/store, else writable
      if (o_goto_trap && tval_cap)
        o_mtval <= i_address_alu;
      else if (i_wr.we && i_wr.addr == `CSR_MTVAL)
        o_mtval <= i_wr.data;
    end
  end

endmodule

// File: hdl/riscv_csrfile.sv
`include "riscv_csr_consts.svh"

module riscv_csrfile (
  input  logic                     i_riscv_csr_clk,
  input  logic                     i_riscv_csr_rst,
  input  logic                     i_riscv_csr_globstall,
  input  logic [`CSR_ADDR_W-1:0]   i_riscv_csr_address,
  input  riscv_csr_pkg::csr_op_e   i_riscv_csr_op,
  input  logic [`CSR_XLEN-1:0]     i_riscv_csr_wdata,
  input  riscv_csr_pkg::irq_vec_t  i_riscv_csr_irq,
  input  riscv_csr_pkg::exc_vec_t  i_riscv_csr_exc,
  input  logic                     i_riscv_csr_instret,
  input  logic [`CSR_XLEN-1:0]     i_riscv_csr_pc,
  input  logic [`CSR_XLEN-1:0]     i_riscv_csr_address_alu,  // faulting load/store address
  output logic [`CSR_XLEN-1:0]     o_riscv_csr_rdata,
  output logic [`CSR_XLEN-1:0]     o_riscv_csr_return_address,  // mepc
  output logic [`CSR_XLEN-1:0]     o_riscv_csr_trap_address,    // mtvec
  output logic                     o_riscv_csr_goto_trap,
  output logic                     o_riscv_csr_return_from_trap,
  output riscv_csr_pkg::priv_lvl_e o_riscv_csr_privlvl
);
  import riscv_csr_pkg::*;

  csr_wr_t                 wr;
  logic                    read_en;
  logic                    addr_missing;
  logic                    mret;
  logic                    csr_illegal;
  mstatus_t                mstatus;
  irq_vec_t                mie;
  irq_vec_t                mip;
  logic [`CSR_XLEN-1:0]    mscratch;
  logic [`MCAUSE_CODE_W:0] mcause;
  logic [`CSR_XLEN-1:0]    mtval;
  logic [`CSR_XLEN-1:0]    mcycle;
  logic [`CSR_XLEN-1:0]    minstret;
  logic [2:0]              mcountinhibit;

  riscv_csr_op_decode u_op_decode (
    .i_riscv_csr_address  (i_riscv_csr_address),
    .i_riscv_csr_op       (i_riscv_csr_op),
    .i_riscv_csr_wdata    (i_riscv_csr_wdata),
    .i_riscv_csr_globstall(i_riscv_csr_globstall),
    .i_rdata              (o_riscv_csr_rdata),   // read-modify-write for set/clear
    .i_addr_missing       (addr_missing),
    .i_priv               (o_riscv_csr_privlvl),
    .o_wr                 (wr),
    .o_read_en            (read_en),
    .o_mret               (mret),
    .o_csr_illegal        (csr_illegal)
  );

  riscv_csr_read_mux u_read_mux (
    .i_address      (i_riscv_csr_address),
    .i_read_en      (read_en),
    .i_mstatus      (mstatus),
    .i_mie          (mie),
    .i_mip          (mip),
    .i_mtvec        (o_riscv_csr_trap_address),
    .i_mscratch     (mscratch),
    .i_mepc         (o_riscv_csr_return_address),
    .i_mcause       (mcause),
    .i_mtval        (mtval),
    .i_mcycle       (mcycle),
    .i_minstret     (minstret),
    .i_mcountinhibit(mcountinhibit),
    .o_rdata        (o_riscv_csr_rdata),
    .o_addr_missing (addr_missing)
  );

  riscv_csr_trap_unit u_trap_unit (
    .i_riscv_csr_clk   (i_riscv_csr_clk),
    .i_riscv_csr_rst   (i_riscv_csr_rst),
    .i_irq             (i_riscv_csr_irq),
    .i_exc             (i_riscv_csr_exc),
    .i_csr_illegal     (csr_illegal),
    .i_mie             (mie),
    .i_mret            (mret),
    .i_wr              (wr),
    .i_pc              (i_riscv_csr_pc),
    .i_address_alu     (i_riscv_csr_address_alu),
    .o_goto_trap       (o_riscv_csr_goto_trap),
    .o_return_from_trap(o_riscv_csr_return_from_trap),
    .o_mstatus         (mstatus),
    .o_priv            (o_riscv_csr_privlvl),
    .o_mepc            (o_riscv_csr_return_address),
    .o_mcause          (mcause),
    .o_mtval           (mtval)
  );

  riscv_csr_machine_regs u_machine_regs (
    .i_riscv_csr_clk(i_riscv_csr_clk),
    .i_riscv_csr_rst(i_riscv_csr_rst),
    .i_wr           (wr),
    .i_irq          (i_riscv_csr_irq),
    .o_mie          (mie),
    .o_mip          (mip),
    .o_mtvec        (o_riscv_csr_trap_address),
    .o_mscratch     (mscratch)
  );

  riscv_csr_counters u_counters (
    .i_riscv_csr_clk(i_riscv_csr_clk),
    .i_riscv_csr_rst(i_riscv_csr_rst),
    .i_wr           (wr),
    .i_instret      (i_riscv_csr_instret),
    .o_mcycle       (mcycle),
    .o_minstret     (minstret),
    .o_mcountinhibit(mcountinhibit)
  );

endmodule

// File: list.f
+incdir+hdl
hdl/riscv_csr_pkg.sv
hdl/riscv_csr_op_decode.sv
hdl/riscv_csr_read_mux.sv
hdl/riscv_csr_trap_unit.sv
hdl/riscv_csr_machine_regs.sv
hdl/riscv_csr_counters.sv
hdl/riscv_csrfile.sv
tb/riscv_csrfile_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the csr file testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module riscv_csrfile_tb -o riscv_csrfile_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/riscv_csrfile_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the result
if grep -q "sim failed" "$LOG"; then
  exit 1
fi
exit 0

// File: tb/riscv_csrfile_tb.sv
`include "riscv_csr_consts.svh"

module riscv_csrfile_tb;
  import riscv_csr_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  // cycle budget: reset, basic, datapath, illegal, exceptions, irq, counters
  localparam int TEST_CYCLES  = RESET_CYCLES + 12 + 64 + 32 + 48 + 40 + 100;

  logic                   clk;
  logic                   rst;
  logic                   globstall;
  logic [`CSR_ADDR_W-1:0] address;
  csr_op_e                op;
  logic [`CSR_XLEN-1:0]   wdata;
  irq_vec_t               irq;
  exc_vec_t               exc;
  logic                   instret;
  logic [`CSR_XLEN-1:0]   pc;
  logic [`CSR_XLEN-1:0]   address_alu;
  logic [`CSR_XLEN-1:0]   rdata;
  logic [`CSR_XLEN-1:0]   ret_addr;
  logic [`CSR_XLEN-1:0]   trap_addr;
  logic                   goto_trap;
  logic                   ret_from_trap;
  priv_lvl_e              privlvl;

  // reference model
  logic                   m_mie;
  logic                   m_mpie;
  logic [1:0]             m_mpp;
  logic [1:0]             m_priv;
  logic [`CSR_XLEN-1:0]   m_mscratch;
  logic [`CSR_XLEN-1:0]   m_mtval;

  logic [31:0]            seed;
  logic [`CSR_XLEN-1:0]   rd_val;     // rdata seen during the last op
  logic                   trap_seen;
  logic                   rft_seen;
  int                     checks;
  int                     errors;
  int                     err_base;   // errors before the running test
  int                     tests_run;
  int                     tests_ok;

  riscv_csrfile UUT (
    .i_riscv_csr_clk             (clk),
    .i_riscv_csr_rst             (rst),
    .i_riscv_csr_globstall       (globstall),
    .i_riscv_csr_address         (address),
    .i_riscv_csr_op              (op),
    .i_riscv_csr_wdata           (wdata),
    .i_riscv_csr_irq             (irq),
    .i_riscv_csr_exc             (exc),
    .i_riscv_csr_instret         (instret),
    .i_riscv_csr_pc              (pc),
    .i_riscv_csr_address_alu     (address_alu),
    .o_riscv_csr_rdata           (rdata),
    .o_riscv_csr_return_address  (ret_addr),
    .o_riscv_csr_trap_address    (trap_addr),
    .o_riscv_csr_goto_trap       (goto_trap),
    .o_riscv_csr_return_from_trap(ret_from_trap),
    .o_riscv_csr_privlvl         (privlvl)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #((TEST_CYCLES + 100) * CLK_PERIOD);
    $display("watchdog expired, tests did not finish within %0d cycles", TEST_CYCLES + 100);
    $display("sim failed");
    $finish;
  end

  // quiet pins and no csr access, only mret may raise return_from_trap
  no_request_no_trap: assert property (@(posedge clk) disable iff (rst)
                                       (exc == '0 && irq == '0 &&
                                        (op == CSR_NOP || op == CSR_MRET))
                                       |-> (!goto_trap && ret_from_trap == (op == CSR_MRET)))
  else
  begin
    errors++;
    $display("trap outputs wrong in a cycle without trap cause at %0t", $time);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    seed = xorshift32(seed);
    hi   = seed;
    seed = xorshift32(seed);
    return {hi, seed};  // two draws per word
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #2;  // inputs move just after the edge
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  // one request cycle, comb outputs sampled mid cycle
  task automatic do_op(input csr_op_e o, input logic [11:0] a, input logic [63:0] d);
    op      = o;
    address = a;
    wdata   = d;
    #5;
    rd_val    = rdata;
    trap_seen = goto_trap;
    rft_seen  = ret_from_trap;
    tick();
    op = CSR_NOP;
  endtask

  task automatic csr_get(input logic [11:0] a, output logic [63:0] v);
    do_op(CSR_READ, a, '0);
    check("goto_trap", 64'(trap_seen), 64'd0);
    v = rd_val;
  endtask

  task automatic csr_rd(input logic [11:0] a, input logic [63:0] exp, input string name);
    logic [63:0] v;
    csr_get(a, v);
    check(name, v, exp);
  endtask

  task automatic csr_wr(input logic [11:0] a, input logic [63:0] d);
    do_op(CSR_WRITE, a, d);
    check("goto_trap", 64'(trap_seen), 64'd0);
  endtask

  task automatic model_trap();
    m_mpie = m_mie;
    m_mie  = 1'b0;
    m_mpp  = m_priv;
    m_priv = 2'b11;  // traps land in m
  endtask

  task automatic model_mret();
    m_mie  = m_mpie;
    m_mpie = 1'b1;
    m_priv = m_mpp;
    m_mpp  = 2'b00;
  endtask

  function automatic logic [63:0] mstatus_exp();
    logic [63:0] v;
    v = 64'd2 << `MSTATUS_UXL_LO;  // uxl fixed at 64 bit
    v[`MSTATUS_MIE_BIT]     = m_mie;
    v[`MSTATUS_MPIE_BIT]    = m_mpie;
    v[`MSTATUS_MPP_LO +: 2] = m_mpp;
    return v;
  endfunction

  task automatic write_mstatus(input logic ie, input logic pie, input logic [1:0] pp);
    logic [63:0] d;
    d = '0;
    d[`MSTATUS_MIE_BIT]     = ie;
    d[`MSTATUS_MPIE_BIT]    = pie;
    d[`MSTATUS_MPP_LO +: 2] = pp;
    csr_wr(`CSR_MSTATUS, d);
    m_mie  = ie;
    m_mpie = pie;
    m_mpp  = (pp == 2'b11) ? 2'b11 : 2'b00;  // only u or m
  endtask

  task automatic do_mret();
    do_op(CSR_MRET, '0, '0);
    check("return_from_trap", 64'(rft_seen), 64'd1);
    model_mret();
    check("privlvl", 64'(privlvl), 64'(m_priv));
  endtask

  // state left behind by a trap, read back in m mode
  task automatic trap_state(input logic [63:0] cause, input logic [63:0] epc);
    check("privlvl", 64'(privlvl), 64'(m_priv));
    check("return_address", ret_addr, epc);
    csr_rd(`CSR_MCAUSE, cause, "mcause");
    csr_rd(`CSR_MEPC, epc, "mepc");
    csr_rd(`CSR_MTVAL, m_mtval, "mtval");
    csr_rd(`CSR_MSTATUS, mstatus_exp(), "mstatus");
  endtask

  task automatic illegal_op(input csr_op_e o, input logic [11:0] a, input logic [63:0] d);
    logic [63:0] pc_v;
    pc_v = rand64();
    pc   = pc_v;
    do_op(o, a, d);
    check("goto_trap", 64'(trap_seen), 64'd1);
    model_trap();
    trap_state(64'd2, pc_v - 64'd4);
  endtask

  task automatic exc_trap(input exc_vec_t e, input logic [3:0] code, input logic ldst);
    logic [63:0] pc_v;
    logic [63:0] alu_v;
    pc_v        = rand64();
    alu_v       = rand64();
    pc          = pc_v;
    address_alu = alu_v;
    exc         = e;
    #5;
    check("goto_trap", 64'(goto_trap), 64'd1);
    tick();
    exc = '0;
    model_trap();
    if (ldst)
      m_mtval = alu_v;  // faulting address only for load/store
    trap_state({60'd0, code}, pc_v - 64'd4);
  endtask

  task automatic pulse_instret();
    instret = 1'b1;
    tick();
    instret = 1'b0;
    tick();
  endtask

  task automatic test_done(input string name);
    tests_run++;
    if (errors == err_base)
    begin
      tests_ok++;
      $display("test %s: ok", name);
    end
    else
      $display("test %s: failed with %0d errors", name, errors - err_base);
    err_base = errors;
  endtask

  initial
  begin : main
    csr_op_e     rop;
    logic [63:0] d;
    logic [63:0] old;
    logic [63:0] v0;
    logic [63:0] v1;
    exc_vec_t    e;
    int          n;
    seed        = 32'h928c7cc4;
    rst         = 1'b1;
    globstall   = 1'b0;
    address     = '0;
    op          = CSR_NOP;
    wdata       = '0;
    irq         = '0;
    exc         = '0;
    instret     = 1'b0;
    pc          = '0;
    address_alu = '0;
    checks      = 0;
    errors      = 0;
    err_base    = 0;
    tests_run   = 0;
    tests_ok    = 0;
    m_mie       = 1'b0;
    m_mpie      = 1'b0;
    m_mpp       = 2'b00;
    m_priv      = 2'b11;  // boots in m
    m_mscratch  = '0;
    m_mtval     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    // reset values
    check("privlvl", 64'(privlvl), 64'd3);
    check("goto_trap", 64'(goto_trap), 64'd0);
    check("return_from_trap", 64'(ret_from_trap), 64'd0);
    check("trap_address", trap_addr, `MTVEC_RESET);
    csr_rd(`CSR_MISA, `MISA_CODE, "misa");
    csr_rd(`CSR_MSTATUS, 64'h0000_0002_0000_0000, "mstatus");
    csr_rd(`CSR_MTVEC, `MTVEC_RESET, "mtvec");
    csr_rd(`CSR_MVENDORID, '0, "mvendorid");
    csr_rd(`CSR_MARCHID, '0, "marchid");
    csr_rd(`CSR_MIMPID, '0, "mimpid");
    csr_rd(`CSR_MHARTID, '0, "mhartid");
    csr_rd(`CSR_MCONFIGPTR, '0, "mconfigptr");
    test_done("reset");

    // random write/set/clear on mscratch
    for (int i = 0; i < 24; i++)
    begin
      d   = rand64();
      old = m_mscratch;
      case (seed % 3)
        32'd0:
        begin
          rop        = CSR_WRITE;
          m_mscratch = d;
        end
        32'd1:
        begin
          rop        = CSR_SET;
          m_mscratch = old | d;
        end
        default:
        begin
          rop        = CSR_CLEAR;
          m_mscratch = old & ~d;
        end
      endcase
      do_op(rop, `CSR_MSCRATCH, d);
      check("goto_trap", 64'(trap_seen), 64'd0);
      check("rdata", rd_val, old);  // old value during the access
      csr_rd(`CSR_MSCRATCH, m_mscratch, "mscratch");
    end
    d    = rand64();
    d[0] = 1'b0;  // direct
    csr_wr(`CSR_MTVEC, d);
    csr_rd(`CSR_MTVEC, d & ~64'h3, "mtvec");
    d    = rand64();
    d[0] = 1'b1;  // vectored, 256 byte base
    csr_wr(`CSR_MTVEC, d);
    csr_rd(`CSR_MTVEC, (d & ~64'hFF) | 64'h1, "mtvec");
    check("trap_address", trap_addr, (d & ~64'hFF) | 64'h1);
    globstall = 1'b1;
    do_op(CSR_WRITE, `CSR_MSCRATCH, ~m_mscratch);
    check("goto_trap", 64'(trap_seen), 64'd0);
    csr_rd(`CSR_MSCRATCH, m_mscratch, "mscratch");  // write was blocked
    globstall = 1'b0;
    test_done("datapath");

    // bad accesses
    illegal_op(CSR_WRITE, `CSR_MVENDORID, rand64());
    csr_rd(`CSR_MVENDORID, '0, "mvendorid");
    illegal_op(CSR_READ, 12'h7C0, '0);  // nothing mapped there
    write_mstatus(1'b0, 1'b0, 2'b00);
    do_mret();  // now in u
    illegal_op(CSR_WRITE, `CSR_MSCRATCH, rand64());
    csr_rd(`CSR_MSCRATCH, m_mscratch, "mscratch");
    test_done("illegal");

    // all flags high then drop one at a time
    e = '1;
    exc_trap(e, 4'd2, 1'b0);
    e.illegal_inst = 1'b0;
    exc_trap(e, 4'd0, 1'b0);
    e.inst_misaligned = 1'b0;
    exc_trap(e, 4'd11, 1'b0);  // ecall from m
    e.ecall = 1'b0;
    exc_trap(e, 4'd4, 1'b1);
    e.load_misaligned = 1'b0;
    exc_trap(e, 4'd6, 1'b1);
    write_mstatus(1'b0, 1'b0, 2'b00);
    do_mret();
    e       = '0;
    e.ecall = 1'b1;
    exc_trap(e, 4'd8, 1'b0);  // ecall from u
    test_done("exceptions");

    // timer irq taken in u, blocked with mie clear, mret reenables
    d                = '0;
    d[`IRQ_MTI_BIT]  = 1'b1;
    csr_wr(`CSR_MIE, d);
    csr_rd(`CSR_MIE, d, "mie");
    write_mstatus(1'b0, 1'b1, 2'b00);
    do_mret();  // mie on, priv u
    v0        = rand64();
    pc        = v0;
    irq.timer = 1'b1;
    #5;
    check("goto_trap", 64'(goto_trap), 64'd1);
    tick();
    model_trap();
    trap_state(64'h8000_0000_0000_0007, v0 - 64'd4);
    csr_rd(`CSR_MIP, 64'h80, "mip");  // pin still high
    do_op(CSR_NOP, '0, '0);
    check("goto_trap", 64'(trap_seen), 64'd0);  // masked by mie
    do_mret();
    v1 = rand64();
    pc = v1;
    #5;
    check("goto_trap", 64'(goto_trap), 64'd1);  // pending again right after mret
    tick();
    irq.timer = 1'b0;
    model_trap();
    trap_state(64'h8000_0000_0000_0007, v1 - 64'd4);
    csr_wr(`CSR_MIE, '0);
    test_done("interrupts");

    // counters
    n = 5 + int'(seed % 16);
    csr_get(`CSR_MCYCLE, v0);
    idle(n - 1);
    csr_get(`CSR_MCYCLE, v1);
    check("mcycle", v1 - v0, 64'(n));
    n = 1 + int'(seed % 8);
    csr_get(`CSR_MINSTRET, v0);
    repeat (n) pulse_instret();
    csr_get(`CSR_MINSTRET, v1);
    check("minstret", v1 - v0, 64'(n));
    csr_wr(`CSR_MCOUNTINHIBIT, 64'h1);
    csr_rd(`CSR_MCOUNTINHIBIT, 64'h1, "mcountinhibit");
    csr_get(`CSR_MCYCLE, v0);
    idle(4);
    csr_get(`CSR_MCYCLE, v1);
    check("mcycle", v1, v0);  // frozen
    csr_get(`CSR_MINSTRET, v0);
    repeat (3) pulse_instret();
    csr_get(`CSR_MINSTRET, v1);
    check("minstret", v1 - v0, 64'd3);  // still counting
    csr_wr(`CSR_MCOUNTINHIBIT, 64'h4);
    csr_get(`CSR_MINSTRET, v0);
    repeat (3) pulse_instret();
    csr_get(`CSR_MINSTRET, v1);
    check("minstret", v1, v0);  // frozen
    csr_get(`CSR_MCYCLE, v0);
    idle(4);
    csr_get(`CSR_MCYCLE, v1);
    check("mcycle", v1 - v0, 64'd5);  // counting again
    csr_wr(`CSR_MCOUNTINHIBIT, '0);
    d = rand64();
    csr_wr(`CSR_MCYCLE, d);
    idle(3);
    csr_rd(`CSR_MCYCLE, d + 64'd3, "mcycle");
    d = rand64();
    csr_wr(`CSR_MINSTRET, d);
    repeat (2) pulse_instret();
    csr_rd(`CSR_MINSTRET, d + 64'd2, "minstret");
    test_done("counters");

    $display("tests ok %0d of %0d, checks %0d, errors %0d",
             tests_ok, tests_run, checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule
